// File: Makefile
VERILATOR  ?= verilator
TOP        := displayTb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb.f
verilog/displayCountPkg.sv
verilog/segmentPkg.sv
verilog/segBankIf.sv
verilog/eventCounter.sv
verilog/decimalSplitter.sv
verilog/segmentEncoder.sv
verilog/digitScanner.sv
verilog/displayTop.sv
testbench/display_checker.sv
testbench/displayTb.sv

// File: testbench/displayTb.sv
// Count display testbench
// Applies a table of step and clear rows, checks the count, the static cathodes
// and the scanned segment bus against values derived from the decimal digits
module displayTb import displayCountPkg::*, segmentPkg::*;;

  localparam int CountWidth  = 7;
  localparam int MaxCount    = 15;
  localparam int ScanDivider = 4;
  localparam int RandomRows  = 8;

  typedef struct packed {
    logic                  isClear;
    logic [15:0]           steps;
    logic [CountWidth-1:0] expCount;
  } rowT;

  logic                  clk   = 1'b0;
  logic                  rstN  = 1'b0;
  logic                  step  = 1'b0;
  logic                  clear = 1'b0;
  logic [CountWidth-1:0] cuenta;
  segPatternT            catodo1;
  segPatternT            catodo2;
  segPatternT            catodo3;
  segPatternT            catodo4;
  logic [NumDigits-1:0]  anodo;
  segPatternT            segOut;

  rowT         stimTable[$];
  int          modelCount  = 0;
  int          edgeCount   = 0;
  int          watchCycles = 0;
  int          checks      = 0;
  int          errors      = 0;
  logic [15:0] lfsrState   = 16'd13321;

  displayTop #(
    .CountWidth (CountWidth),
    .MaxCount   (MaxCount),
    .ScanDivider(ScanDivider)
  ) dut_i (
    .clk    (clk),
    .rstN   (rstN),
    .step   (step),
    .clear  (clear),
    .cuenta (cuenta),
    .catodo1(catodo1),
    .catodo2(catodo2),
    .catodo3(catodo3),
    .catodo4(catodo4),
    .anodo  (anodo),
    .segOut (segOut)
  );

  always #20 clk = ~clk;

  // Edges since reset release, the scan position follows from this
  always @(posedge clk) begin
    if (!rstN) begin
      edgeCount <= 0;
    end else begin
      edgeCount <= edgeCount + 1;
    end
  end

  // 16-bit Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic takeBits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsrState[0]);
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // Cathode byte of one digit position for a displayed value
  function automatic segPatternT expectedByte(input int value, input int idx);
    int scaled;
    scaled = value;
    if (value > MaxCount) begin
      return SegError;
    end
    for (int i = 0; i < idx; i++) begin
      scaled = scaled / 10;
    end
    return digitPattern(digitT'(scaled % 10));
  endfunction

  task automatic addRow(input logic isClear, input int steps);
    rowT row;
    modelCount     = isClear ? 0 : (modelCount + steps) % (1 << CountWidth);
    row.isClear    = isClear;
    row.steps      = 16'(steps);
    row.expCount   = CountWidth'(modelCount);
    stimTable.push_back(row);
  endtask

  task automatic checkCount(input logic [CountWidth-1:0] got, input logic [CountWidth-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH cuenta got=0x%h exp=0x%h", got, exp);
    end
  endtask

  task automatic checkPattern(input segPatternT got, input segPatternT exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got=0x%h exp=0x%h", name, got, exp);
    end
  endtask

  task automatic checkAnode(input logic [NumDigits-1:0] got, input logic [NumDigits-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH anodo got=0x%h exp=0x%h", got, exp);
    end
  endtask

  task automatic checkDisplay(input logic [CountWidth-1:0] expCount);
    checkCount(cuenta, expCount);
    checkPattern(catodo1, expectedByte(int'(expCount), 0), "catodo1");
    checkPattern(catodo2, expectedByte(int'(expCount), 1), "catodo2");
    checkPattern(catodo3, expectedByte(int'(expCount), 2), "catodo3");
    checkPattern(catodo4, expectedByte(int'(expCount), 3), "catodo4");
  endtask

  // Idle stretch long enough for a full anode rotation
  task automatic scanIdle(input int value);
    logic [NumDigits-1:0] expAnode;
    logic [NumDigits-1:0] seen;
    int                   sel;
    seen = '0;
    repeat (NumDigits * ScanDivider) begin
      @(negedge clk);
      sel      = (edgeCount / ScanDivider) % NumDigits;
      expAnode = ~(NumDigits'(1) << sel);
      checkAnode(anodo, expAnode);
      checkPattern(segOut, expectedByte(value, sel), "segOut");
      seen = seen | ~anodo;
    end
    if (seen != '1) begin
      errors++;
      $display("Scan error: not every digit was selected during the idle stretch");
    end
  endtask

  task automatic applyRow(input rowT row, input int rowIdx);
    int errBefore;
    errBefore = errors;
    @(posedge clk);
    if (row.isClear) begin
      // Step is held high too, clear must win
      clear <= 1'b1;
      step  <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      step  <= 1'b0;
    end else if (row.steps > 0) begin
      step <= 1'b1;
      repeat (row.steps) @(posedge clk);
      step <= 1'b0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    checkDisplay(row.expCount);
    $display("row %0d %s steps=%0d cuenta=%0d: %s", rowIdx, row.isClear ? "clear" : "step",
             row.steps, row.expCount, (errors == errBefore) ? "ok" : "error");
  endtask

  initial begin
    int randSteps;
    int stepSum;
    int errBefore;
    // Sweep one step at a time up to the first over-range value
    for (int v = 0; v <= MaxCount; v++) begin
      addRow(1'b0, 1);
    end
    addRow(1'b1, 0);
    addRow(1'b0, 20);
    addRow(1'b0, 100);
    // Lands exactly on the width limit and wraps to zero
    addRow(1'b0, 8);
    addRow(1'b0, 5);
    addRow(1'b1, 0);
    for (int r = 0; r < RandomRows; r++) begin
      takeBits(4, randSteps);
      addRow(1'b0, randSteps);
    end
    // End on a value whose ones and tens patterns differ, so the scan can tell digits apart
    addRow(1'b1, 0);
    addRow(1'b0, 12);
    stepSum = 0;
    foreach (stimTable[i]) begin
      stepSum += int'(stimTable[i].steps);
    end
    watchCycles = stepSum + 3 * stimTable.size() + 200;

    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    checkDisplay('0);
    scanIdle(0);
    $display("reset and scan at 0: %s", (errors == 0) ? "ok" : "error");

    foreach (stimTable[i]) begin
      applyRow(stimTable[i], i);
    end
    errBefore = errors;
    scanIdle(modelCount);
    $display("final scan at %0d: %s", modelCount, (errors == errBefore) ? "ok" : "error");

    $display("%0d rows, %0d checks, %0d errors", stimTable.size(), checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table once it is built
  initial begin
    wait (watchCycles > 0);
    repeat (watchCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchCycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: testbench/display_checker.sv
// Display checker
// Scan and cathode timing properties, bound into the display top level
module display_checker import displayCountPkg::*, segmentPkg::*; #(
  parameter int CountWidth = 7
) (
  input logic                  clk,
  input logic                  rstN,
  input logic [CountWidth-1:0] cuenta,
  input segPatternT            catodo1,
  input segPatternT            catodo2,
  input segPatternT            catodo3,
  input segPatternT            catodo4,
  input logic [NumDigits-1:0]  anodo,
  input segPatternT            segOut
);

  logic [4*8-1:0] bankBytes;

  assign bankBytes = {catodo4, catodo3, catodo2, catodo1};

  anodeOneCold: assert property (@(posedge clk) disable iff (!rstN) $onehot(~anodo))
    else $error("anodo is not one-cold");

  segOutKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(segOut))
    else $error("segOut holds an unknown value");

  // Splitter plus encoder take two cycles, so three equal samples settle the bank
  cathodeStable: assert property (@(posedge clk) disable iff (!rstN)
    ($past(rstN, 3) && cuenta == $past(cuenta, 1) && cuenta == $past(cuenta, 2) &&
     cuenta == $past(cuenta, 3)) |-> $stable(bankBytes))
    else $error("cathode bytes changed while cuenta was stable");

  anodeAdvance: assert property (@(posedge clk) disable iff (!rstN)
    $changed(anodo) |-> anodo == $past({anodo[NumDigits-2:0], anodo[NumDigits-1]}))
    else $error("anodo skipped or reversed a digit");

endmodule

bind displayTop display_checker #(
  .CountWidth(CountWidth)
) checkerInst (
  .clk    (clk),
  .rstN   (rstN),
  .cuenta (cuenta),
  .catodo1(catodo1),
  .catodo2(catodo2),
  .catodo3(catodo3),
  .catodo4(catodo4),
  .anodo  (anodo),
  .segOut (segOut)
);

// File: verilog/decimalSplitter.sv
// Decimal splitter
// Registers the four decimal digits of the count and flags values above MaxCount
module decimalSplitter import displayCountPkg::*; #(
  parameter int CountWidth = displayCountPkg::CountWidth,
  parameter int MaxCount   = 15
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [CountWidth-1:0] cuenta,
  output digitsT                digits,
  output logic                  overRange
);

  // Four digits never show more than MaxDisplayValue
  localparam int Limit = (MaxCount < MaxDisplayValue) ? MaxCount : MaxDisplayValue;

  digitsT digitsNext;
  logic   overNext;

  // Repeated division by ten, ones digit first
  always_comb begin
    logic [CountWidth-1:0] rest;
    rest = cuenta;
    for (int i = 0; i < NumDigits; i++) begin
      digitsNext[i] = digitT'(rest % DigitBase);
      rest          = CountWidth'(rest / DigitBase);
    end
  end

  assign overNext = (32'(cuenta) > Limit);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      digits    <= '0;
      overRange <= 1'b0;
    end else begin
      // Digits are kept even when over range
      digits    <= digitsNext;
      overRange <= overNext;
    end
  end

endmodule

// File: verilog/digitScanner.sv
// Digit scanner
// Rotates a one-cold anode and multiplexes the cathode bytes onto one segment bus
module digitScanner import displayCountPkg::*, segmentPkg::*; #(
  parameter int ScanDivider = 4
) (
  input  logic                 clk,
  input  logic                 rstN,
  segBankIf.scannerMp          bank,
  output segPatternT           catodo1,
  output segPatternT           catodo2,
  output segPatternT           catodo3,
  output segPatternT           catodo4,
  output logic [NumDigits-1:0] anodo,
  output segPatternT           segOut
);

  localparam int DivWidth = (ScanDivider > 1) ? $clog2(ScanDivider) : 1;
  localparam int SelWidth = $clog2(NumDigits);

  logic [DivWidth-1:0] divCount;
  logic [SelWidth-1:0] digitSel;
  logic [SelWidth-1:0] selNext;
  logic                tick;
  segPatternT          bankByte [NumDigits];

  // Static cathode buses straight from the bank
  assign catodo1 = bank.catodo1;
  assign catodo2 = bank.catodo2;
  assign catodo3 = bank.catodo3;
  assign catodo4 = bank.catodo4;

  assign bankByte[0] = bank.catodo1;
  assign bankByte[1] = bank.catodo2;
  assign bankByte[2] = bank.catodo3;
  assign bankByte[3] = bank.catodo4;

  assign tick    = (32'(divCount) == ScanDivider - 1);
  assign selNext = tick ? digitSel + 1'b1 : digitSel;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      divCount <= '0;
      digitSel <= '0;
      anodo    <= {{(NumDigits-1){1'b1}}, 1'b0};
      segOut   <= SegBlank;
    end else begin
      divCount <= tick ? '0 : divCount + 1'b1;
      digitSel <= selNext;
      // Anode and segment byte are loaded together so they always match
      anodo    <= ~(NumDigits'(1) << selNext);
      segOut   <= bankByte[selNext];
    end
  end

endmodule

// File: verilog/displayCountPkg.sv
// Count display definitions
// Widths and decimal limits shared by the counter, splitter and encoders
package displayCountPkg;

  // Default width of the step counter
  localparam int CountWidth = 7;

  // Digits on the board display
  localparam int NumDigits = 4;

  localparam int DigitWidth = 4;

  // Decimal base and largest value four digits can show
  localparam int DigitBase = 10;
  localparam int MaxDisplayValue = 9999;

  // One decimal digit, 0 to 9 in normal use
  typedef logic [DigitWidth-1:0] digitT;

  // All display digits, index 0 is the ones digit
  typedef digitT [NumDigits-1:0] digitsT;

endpackage

// File: verilog/displayTop.sv
// Four-digit count display
// Step counter, decimal split, segment encoders and anode scanner
module displayTop import displayCountPkg::*, segmentPkg::*; #(
  parameter int CountWidth  = displayCountPkg::CountWidth,
  parameter int MaxCount    = 15,
  parameter int ScanDivider = 4
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  step,
  input  logic                  clear,
  output logic [CountWidth-1:0] cuenta,
  output segPatternT            catodo1,
  output segPatternT            catodo2,
  output segPatternT            catodo3,
  output segPatternT            catodo4,
  output logic [NumDigits-1:0]  anodo,
  output segPatternT            segOut
);

  digitsT digits;
  logic   overRange;

  segBankIf bankIf ();

  eventCounter #(
    .CountWidth(CountWidth)
  ) uCounter (
    .clk   (clk),
    .rstN  (rstN),
    .step  (step),
    .clear (clear),
    .cuenta(cuenta)
  );

  decimalSplitter #(
    .CountWidth(CountWidth),
    .MaxCount  (MaxCount)
  ) uSplitter (
    .clk      (clk),
    .rstN     (rstN),
    .cuenta   (cuenta),
    .digits   (digits),
    .overRange(overRange)
  );

  // One encoder per digit, instance k fills bank byte k+1
  for (genvar k = 0; k < NumDigits; k++) begin : genEncoder
    segmentEncoder #(
      .Index(k)
    ) uEncoder (
      .clk      (clk),
      .rstN     (rstN),
      .digit    (digits[k]),
      .overRange(overRange),
      .bank     (bankIf.encoderMp)
    );
  end

  digitScanner #(
    .ScanDivider(ScanDivider)
  ) uScanner (
    .clk    (clk),
    .rstN   (rstN),
    .bank   (bankIf.scannerMp),
    .catodo1(catodo1),
    .catodo2(catodo2),
    .catodo3(catodo3),
    .catodo4(catodo4),
    .anodo  (anodo),
    .segOut (segOut)
  );

endmodule

// File: verilog/eventCounter.sv
// Step counter
// Binary count of step pulses, wraps at the width limit
module eventCounter #(
  parameter int CountWidth = displayCountPkg::CountWidth
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  step,
  input  logic                  clear,
  output logic [CountWidth-1:0] cuenta
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cuenta <= '0;
    end else if (clear) begin
      // Clear has priority over a step in the same cycle
      cuenta <= '0;
    end else if (step) begin
      // All-ones rolls over to zero
      cuenta <= cuenta + 1'b1;
    end
  end

endmodule

// File: verilog/segBankIf.sv
// Cathode bank
// Four cathode bytes from the digit encoders to the scanner
interface segBankIf import segmentPkg::*; ();

  // catodo1 is the ones digit
  segPatternT catodo1;
  segPatternT catodo2;
  segPatternT catodo3;
  segPatternT catodo4;

  // Each encoder drives one byte of the bank
  modport encoderMp (
    output catodo1, catodo2, catodo3, catodo4
  );

  modport scannerMp (
    input catodo1, catodo2, catodo3, catodo4
  );

endinterface

// File: verilog/segmentEncoder.sv
// Digit segment encoder
// Registers the cathode pattern of one digit, or the error pattern when over range
module segmentEncoder import displayCountPkg::*, segmentPkg::*; #(
  parameter int Index = 0
) (
  input  logic               clk,
  input  logic               rstN,
  input  digitT              digit,
  input  logic               overRange,
  segBankIf.encoderMp        bank
);

  segPatternT patternQ;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      patternQ <= SegBlank;
    end else begin
      patternQ <= overRange ? SegError : digitPattern(digit);
    end
  end

  // Drive only the bank byte of this digit position
  generate
    case (Index)
      0:       assign bank.catodo1 = patternQ;
      1:       assign bank.catodo2 = patternQ;
      2:       assign bank.catodo3 = patternQ;
      default: assign bank.catodo4 = patternQ;
    endcase
  endgenerate

endmodule

// File: verilog/segmentPkg.sv
// Seven-segment cathode definitions
// Active-low byte, segments a to g in bits 7 to 1, decimal point in bit 0
package segmentPkg;
  import displayCountPkg::*;

  typedef logic [7:0] segPatternT;

  // All segments dark
  localparam segPatternT SegBlank = 8'b1111_1111;

  // Over-range display, only b and c lit ("1")
  localparam segPatternT SegError = 8'b1001_1111;

  // Cathode pattern of one decimal digit, dp always off
  function automatic segPatternT digitPattern(input digitT digit);
    segPatternT pattern;
    case (digit)
      4'd0:    pattern = 8'b0000_0011;
      4'd1:    pattern = 8'b1001_1111;
      4'd2:    pattern = 8'b0010_0101;
      4'd3:    pattern = 8'b0000_1101;
      4'd4:    pattern = 8'b1001_1001;
      4'd5:    pattern = 8'b0100_1001;
      4'd6:    pattern = 8'b0100_0001;
      4'd7:    pattern = 8'b0001_1111;
      4'd8:    pattern = 8'b0000_0001;
      4'd9:    pattern = 8'b0001_1001;
      // Codes 10 to 15 are not decimal
      default: pattern = SegBlank;
    endcase
    return pattern;
  endfunction

endpackage
